// File: Bender.yml
package:
  name: conv_window_top

sources:
  # packages first, then the RTL bottom up
  - logic/conv_cfg_pkg.sv
  - logic/window_types_pkg.sv
  - logic/feature_sram.sv
  - logic/row_fetch.sv
  - logic/im2col_window.sv
  - logic/conv_window_top.sv

  - target: test
    files:
      - tests/tb_clock.sv
      - tests/tb_conv_window.sv

// File: conv_window_top.f
logic/conv_cfg_pkg.sv
logic/window_types_pkg.sv
logic/feature_sram.sv
logic/row_fetch.sv
logic/im2col_window.sv
logic/conv_window_top.sv
tests/tb_clock.sv
tests/tb_conv_window.sv

// File: logic/conv_cfg_pkg.sv
/*
 * convolution window configuration
 * geometry of the feature map SRAM, the tile rows and the
 * output lane vector shared by the fetch and window blocks
 */
package conv_cfg_pkg;

    // feature map SRAM
    localparam int WORD_BYTES = 8;      // bytes per word, byte 0 in bits 7:0
    localparam int SRAM_DEPTH = 1024;
    localparam int ADDR_W     = 10;

    // tile rows, 16 lanes plus two extra taps
    localparam int ROW_LEN_S1 = 18;
    localparam int ROW_LEN_S2 = 33;     // 2*15 + 3
    localparam int ROWS_W     = 8;      // width of the row count

    // kernel taps and output lanes
    localparam int TAPS  = 3;
    localparam int LANES = 16;

    // longest row plus a misaligned start word plus one word in flight
    localparam int WINDOW_WORDS = 6;

endpackage

// File: logic/conv_window_top.sv
/*
 * convolution input stage
 * feature map SRAM with a load port, the row fetch controller and
 * the im2col window that turns tile rows into 16-lane tap vectors
 */
module conv_window_top (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  clr,
    input  logic                                  start,
    input  logic                                  stride2_en,
    input  logic [conv_cfg_pkg::ADDR_W-1:0]       start_word,
    input  logic [conv_cfg_pkg::ROWS_W-1:0]       row_count,
    input  logic                                  tap_take,
    input  logic                                  load_en,
    input  logic [conv_cfg_pkg::ADDR_W-1:0]       load_addr,
    input  logic [conv_cfg_pkg::WORD_BYTES*8-1:0] load_data,
    output logic [7:0]                            tap_bytes [conv_cfg_pkg::LANES-1:0],
    output logic                                  tap_valid,
    output logic [window_types_pkg::TAP_W-1:0]    tap_index,
    output logic                                  busy,
    output logic                                  done
);

    logic                                  rd_en;
    logic [conv_cfg_pkg::ADDR_W-1:0]       rd_addr;
    logic [conv_cfg_pkg::WORD_BYTES*8-1:0] rd_data;
    logic                                  rd_vld;
    logic                                  word_req;   // window has a free slot
    logic                                  row_done;   // third tap of a row taken

    feature_sram sram0 (
        .clk       (clk),
        .rst_n     (rst_n),
        .load_en   (load_en),
        .load_addr (load_addr),
        .load_data (load_data),
        .rd_en     (rd_en),
        .rd_addr   (rd_addr),
        .rd_data   (rd_data),
        .rd_vld    (rd_vld)
    );

    row_fetch fetch0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .clr        (clr),
        .start      (start),
        .stride2_en (stride2_en),
        .start_word (start_word),
        .row_count  (row_count),
        .word_req   (word_req),
        .row_done   (row_done),
        .rd_en      (rd_en),
        .rd_addr    (rd_addr),
        .busy       (busy),
        .done       (done)
    );

    // done also empties the window for the next run
    im2col_window window0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .clr        (clr),
        .run_done   (done),
        .stride2_en (stride2_en),
        .rd_data    (rd_data),
        .rd_vld     (rd_vld),
        .tap_take   (tap_take),
        .word_req   (word_req),
        .tap_bytes  (tap_bytes),
        .tap_valid  (tap_valid),
        .tap_index  (tap_index),
        .row_done   (row_done)
    );

endmodule

// File: logic/feature_sram.sv
/*
 * feature map SRAM
 * holds the input feature map as 8-byte words, written through
 * the load port and read synchronously with a one-cycle latency
 */
module feature_sram (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  load_en,
    input  logic [conv_cfg_pkg::ADDR_W-1:0]       load_addr,
    input  logic [conv_cfg_pkg::WORD_BYTES*8-1:0] load_data,
    input  logic                                  rd_en,
    input  logic [conv_cfg_pkg::ADDR_W-1:0]       rd_addr,
    output logic [conv_cfg_pkg::WORD_BYTES*8-1:0] rd_data,
    output logic                                  rd_vld
);

    logic [conv_cfg_pkg::WORD_BYTES*8-1:0] mem [conv_cfg_pkg::SRAM_DEPTH];

    // load port, one word per clock
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[rd_addr];   // data valid the cycle after rd_en
        end
    end

    // marks the cycle rd_data carries a fresh word
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_vld <= 1'b0;
        end
        else begin
            rd_vld <= rd_en;
        end
    end

endmodule

// File: logic/im2col_window.sv
/*
 * im2col window
 * appends incoming SRAM words to a byte window, cuts one tile row
 * out of it at the running byte offset and presents the three
 * kernel taps of that row as 16-lane byte vectors, one after the other
 */
module im2col_window (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic                                  clr,
    input  logic                                  run_done,
    input  logic                                  stride2_en,
    input  logic [conv_cfg_pkg::WORD_BYTES*8-1:0] rd_data,
    input  logic                                  rd_vld,
    input  logic                                  tap_take,
    output logic                                  word_req,
    output logic [7:0]                            tap_bytes [conv_cfg_pkg::LANES-1:0],
    output logic                                  tap_valid,
    output logic [window_types_pkg::TAP_W-1:0]    tap_index,
    output logic                                  row_done
);

    window_types_pkg::win_state_e state;

    // word 0 at the lsb end, newest word on top
    logic [conv_cfg_pkg::WINDOW_WORDS*conv_cfg_pkg::WORD_BYTES*8-1:0] win_q;
    logic [conv_cfg_pkg::WINDOW_WORDS*conv_cfg_pkg::WORD_BYTES*8-1:0] win_next;

    logic [$clog2(conv_cfg_pkg::WINDOW_WORDS+1)-1:0] word_cnt;   // words held
    logic [$clog2(conv_cfg_pkg::WORD_BYTES)-1:0]     byte_off;   // row start in word 0

    logic [7:0] hold_q [conv_cfg_pkg::ROW_LEN_S2];   // frozen row

    logic [5:0] row_len;
    logic [5:0] row_end;     // byte_off + row_len, at most 40
    logic [2:0] drop;        // words retired when a row is frozen
    logic       row_ready;
    logic       freeze;
    logic       take;

    assign row_len = stride2_en ? 6'(conv_cfg_pkg::ROW_LEN_S2) : 6'(conv_cfg_pkg::ROW_LEN_S1);
    assign row_end = {3'b000, byte_off} + row_len;

    // word_cnt * 8 bytes present against the bytes the row needs
    assign row_ready = {word_cnt, 3'b000} >= row_end;
    assign freeze    = (state == window_types_pkg::WS_SHIFT) && row_ready;
    assign drop      = freeze ? row_end[5:3] : 3'd0;   // whole words passed by this row

    assign tap_valid = state == window_types_pkg::WS_PAUSE;
    assign take      = tap_valid && tap_take;
    assign row_done  = take && (tap_index == window_types_pkg::TAP_W'(conv_cfg_pkg::TAPS - 1));

    // a word on rd_vld already occupies a slot
    assign word_req = (word_cnt + rd_vld) < conv_cfg_pkg::WINDOW_WORDS;

    // retire the words of a frozen row, then append the new word behind the rest
    always_comb begin
        win_next = win_q >> (drop * (conv_cfg_pkg::WORD_BYTES * 8));
        if (rd_vld) begin
            win_next[(word_cnt - drop) * (conv_cfg_pkg::WORD_BYTES * 8) +:
                     conv_cfg_pkg::WORD_BYTES * 8] = rd_data;
        end
    end

    always_ff @(posedge clk) begin
        win_q <= win_next;
    end

    // cut the row out at the current offset
    always_ff @(posedge clk) begin
        if (freeze) begin
            for (int j = 0; j < conv_cfg_pkg::ROW_LEN_S2; j++) begin
                hold_q[j] <= win_q[(int'(byte_off) + j) * 8 +: 8];
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= window_types_pkg::WS_IDLE;
            word_cnt  <= '0;
            byte_off  <= '0;
            tap_index <= '0;
        end
        else if (clr || run_done) begin
            // new run starts word aligned on an empty window
            state     <= window_types_pkg::WS_IDLE;
            word_cnt  <= '0;
            byte_off  <= '0;
            tap_index <= '0;
        end
        else begin
            word_cnt <= word_cnt - drop + rd_vld;

            if (freeze) begin
                byte_off <= row_end[2:0];   // next row start, modulo the word size
            end

            if (take) begin
                if (tap_index == window_types_pkg::TAP_W'(conv_cfg_pkg::TAPS - 1)) begin
                    tap_index <= '0;
                end
                else begin
                    tap_index <= tap_index + 1'b1;
                end
            end

            case (state)
                window_types_pkg::WS_IDLE: begin
                    if (rd_vld) begin
                        state <= window_types_pkg::WS_SHIFT;
                    end
                end
                window_types_pkg::WS_SHIFT: begin
                    if (freeze) begin
                        state <= window_types_pkg::WS_PAUSE;
                    end
                end
                window_types_pkg::WS_PAUSE: begin
                    // words keep arriving, the next row waits
                    if (row_done) begin
                        state <= window_types_pkg::WS_SHIFT;
                    end
                end
                default: state <= window_types_pkg::WS_IDLE;
            endcase
        end
    end

    // lane i of tap k reads byte (i << stride) + k of the row
    always_comb begin
        for (int i = 0; i < conv_cfg_pkg::LANES; i++) begin
            tap_bytes[i] = hold_q[(i << stride2_en) + tap_index];
        end
    end

endmodule

// File: logic/row_fetch.sv
/*
 * row fetch controller
 * streams the words of a run of tile rows from the SRAM, starting
 * at start_word, while the window asks for data; counts finished
 * rows and flags the end of the run
 */
module row_fetch (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic                              clr,
    input  logic                              start,
    input  logic                              stride2_en,
    input  logic [conv_cfg_pkg::ADDR_W-1:0]   start_word,
    input  logic [conv_cfg_pkg::ROWS_W-1:0]   row_count,
    input  logic                              word_req,
    input  logic                              row_done,
    output logic                              rd_en,
    output logic [conv_cfg_pkg::ADDR_W-1:0]   rd_addr,
    output logic                              busy,
    output logic                              done
);

    window_types_pkg::fetch_state_e state;

    logic [conv_cfg_pkg::ROWS_W+5:0] row_len;
    logic [conv_cfg_pkg::ROWS_W+5:0] run_bytes;   // row_count * row length
    logic [conv_cfg_pkg::ROWS_W+2:0] run_words;
    logic [conv_cfg_pkg::ROWS_W+2:0] words_left;
    logic [conv_cfg_pkg::ROWS_W-1:0] rows_total;
    logic [conv_cfg_pkg::ROWS_W-1:0] rows_seen;

    assign row_len = stride2_en ? (conv_cfg_pkg::ROWS_W+6)'(conv_cfg_pkg::ROW_LEN_S2)
                                : (conv_cfg_pkg::ROWS_W+6)'(conv_cfg_pkg::ROW_LEN_S1);
    assign run_bytes = row_count * row_len;

    // round up to whole 8-byte words
    assign run_words = run_bytes[conv_cfg_pkg::ROWS_W+5:3]
                     + (conv_cfg_pkg::ROWS_W+3)'(|run_bytes[2:0]);

    assign busy  = (state == window_types_pkg::FS_FETCH) || (state == window_types_pkg::FS_DRAIN);
    assign done  = state == window_types_pkg::FS_DONE;
    assign rd_en = (state == window_types_pkg::FS_FETCH) && word_req && !clr;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= window_types_pkg::FS_IDLE;
            rd_addr    <= '0;
            words_left <= '0;
            rows_total <= '0;
            rows_seen  <= '0;
        end
        else if (clr) begin
            state      <= window_types_pkg::FS_IDLE;
            rd_addr    <= '0;
            words_left <= '0;
            rows_total <= '0;
            rows_seen  <= '0;
        end
        else begin
            case (state)
                window_types_pkg::FS_IDLE, window_types_pkg::FS_DONE: begin
                    state <= window_types_pkg::FS_IDLE;
                    if (start) begin
                        rd_addr    <= start_word;
                        words_left <= run_words;
                        rows_total <= row_count;
                        rows_seen  <= '0;
                        state      <= (row_count == '0) ? window_types_pkg::FS_DONE
                                                        : window_types_pkg::FS_FETCH;
                    end
                end
                window_types_pkg::FS_FETCH: begin
                    if (rd_en) begin
                        rd_addr    <= rd_addr + 1'b1;
                        words_left <= words_left - 1'b1;
                        if (words_left == 1) begin
                            state <= window_types_pkg::FS_DRAIN;   // last word issued
                        end
                    end
                end
                window_types_pkg::FS_DRAIN: begin
                    state <= window_types_pkg::FS_DRAIN;   // wait for the rows to be taken
                end
                default: state <= window_types_pkg::FS_IDLE;
            endcase

            // rows finish during FETCH as well as DRAIN
            if (busy && row_done) begin
                rows_seen <= rows_seen + 1'b1;
                if (rows_seen == rows_total - 1'b1) begin
                    state <= window_types_pkg::FS_DONE;
                end
            end
        end
    end

endmodule

// File: logic/window_types_pkg.sv
/*
 * window types
 * state encodings of the row fetch and im2col window FSMs
 * and the width of the tap index
 */
package window_types_pkg;

    typedef enum logic [1:0] {
        FS_IDLE,
        FS_FETCH,   // issuing reads while the window has room
        FS_DRAIN,   // all words read, rows still being taken
        FS_DONE
    } fetch_state_e;

    typedef enum logic [1:0] {
        WS_IDLE,
        WS_SHIFT,   // collecting words until a full row is present
        WS_PAUSE    // row held, taps being taken
    } win_state_e;

    localparam int TAP_W = 2;

endpackage

// File: tests/tb_clock.sv
/*
 * testbench clock and reset
 * free running 100 ns clock, rst_n held low for the first
 * three rising edges
 */
module tb_clock (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 1ps;

    localparam int HALF_PERIOD  = 50;
    localparam int RESET_CYCLES = 3;

    initial begin
        clk = 1'b0;
        forever #HALF_PERIOD clk = ~clk;
    end

    initial begin
        rst_n = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk);
        #10 rst_n = 1'b1;   // release clear of the edge
    end

endmodule

// File: tests/tb_conv_window.sv
/*
 * convolution input stage testbench
 * loads random words into the feature SRAM, runs tile rows at both
 * strides with and without consumer stalls, checks every tap against
 * a reference model and watches busy, done and clr
 */
module tb_conv_window;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int  CLK_PERIOD  = 100;
    localparam int  DRIVE_DELAY = 10;
    localparam int  LOAD_WORDS  = 64;
    localparam int  TOTAL_ROWS  = 4 + 3 + 5 + 2 + 6 + 2;
    localparam int  WATCHDOG_CYCLES = TOTAL_ROWS * 3 * 40 + 600;   // margin for load and idle
    localparam int  LANE_BITS   = conv_cfg_pkg::LANES * 8;

    logic                                  clk;
    logic                                  rst_n;
    logic                                  clr;
    logic                                  start;
    logic                                  stride2_en;
    logic [conv_cfg_pkg::ADDR_W-1:0]       start_word;
    logic [conv_cfg_pkg::ROWS_W-1:0]       row_count;
    logic                                  tap_take;
    logic                                  load_en;
    logic [conv_cfg_pkg::ADDR_W-1:0]       load_addr;
    logic [conv_cfg_pkg::WORD_BYTES*8-1:0] load_data;
    logic [7:0]                            tap_bytes [conv_cfg_pkg::LANES-1:0];
    logic                                  tap_valid;
    logic [window_types_pkg::TAP_W-1:0]    tap_index;
    logic                                  busy;
    logic                                  done;

    logic [conv_cfg_pkg::WORD_BYTES*8-1:0] mem_img [conv_cfg_pkg::SRAM_DEPTH];
    logic [LANE_BITS-1:0]                  tap_flat;
    logic [LANE_BITS-1:0]                  held_bytes;
    logic [window_types_pkg::TAP_W-1:0]    held_index;
    logic [31:0]                           lfsr_state = 32'h68b9a6b4;

    int exp_start_word;
    bit exp_stride;
    int exp_takes;
    int take_count;
    int done_count;
    bit in_run;
    bit hold_seen;
    bit took_last;
    int errors;
    int tests_passed;
    int tests_failed;

    tb_clock clock0 (
        .clk   (clk),
        .rst_n (rst_n)
    );

    conv_window_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .clr        (clr),
        .start      (start),
        .stride2_en (stride2_en),
        .start_word (start_word),
        .row_count  (row_count),
        .tap_take   (tap_take),
        .load_en    (load_en),
        .load_addr  (load_addr),
        .load_data  (load_data),
        .tap_bytes  (tap_bytes),
        .tap_valid  (tap_valid),
        .tap_index  (tap_index),
        .busy       (busy),
        .done       (done)
    );

    always_comb begin
        for (int i = 0; i < conv_cfg_pkg::LANES; i++) begin
            tap_flat[i*8 +: 8] = tap_bytes[i];
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic logic [63:0] take_bits(input int n);
        logic [63:0] v;
        v = '0;
        for (int b = 0; b < n; b++) begin
            lfsr_state = lfsr_next(lfsr_state);   // one step per bit
            v = {v[62:0], lfsr_state[0]};
        end
        return v;
    endfunction

    // lane i of tap k is byte (i << stride) + k of row n
    function automatic logic [LANE_BITS-1:0] ref_tap(
        input logic [63:0] img [conv_cfg_pkg::SRAM_DEPTH],
        input int          sw,
        input bit          s2,
        input int          row,
        input int          tap
    );
        logic [LANE_BITS-1:0] v;
        int row_len;
        int pos;
        row_len = s2 ? 33 : 18;
        for (int i = 0; i < conv_cfg_pkg::LANES; i++) begin
            pos = sw * 8 + row * row_len + (i << s2) + tap;
            v[i*8 +: 8] = img[pos / 8][(pos % 8) * 8 +: 8];
        end
        return v;
    endfunction

    task automatic report_mismatch(input string msg);
        $display("CHECK FAILED @ %0d ns: %s", $time, msg);
        errors++;
    endtask

    // compare every take, and hold stability while stalled
    always @(negedge clk) begin
        logic [LANE_BITS-1:0] exp_bytes;
        if (rst_n && tap_valid) begin
            if (hold_seen) begin
                assert (tap_flat == held_bytes && tap_index == held_index)
                else report_mismatch("tap changed while stalled");
            end
            if (tap_take) begin
                exp_bytes = ref_tap(mem_img, exp_start_word, exp_stride,
                                    take_count / 3, take_count % 3);
                assert (tap_flat == exp_bytes)
                else report_mismatch($sformatf("row %0d tap %0d got %h expected %h",
                                     take_count / 3, take_count % 3, tap_flat, exp_bytes));
                assert (int'(tap_index) == take_count % 3)
                else report_mismatch($sformatf("tap_index %0d expected %0d",
                                     tap_index, take_count % 3));
                take_count++;
                hold_seen = 1'b0;
            end
            else begin
                hold_seen  = 1'b1;
                held_bytes = tap_flat;
                held_index = tap_index;
            end
        end
        else begin
            hold_seen = 1'b0;
        end
    end

    // busy and done around each run
    always @(negedge clk) begin
        if (rst_n) begin
            if (done) begin
                done_count++;
                in_run = 1'b0;
                assert (took_last) else report_mismatch("done not one cycle after last take");
                assert (take_count == exp_takes)
                else report_mismatch($sformatf("%0d takes expected %0d", take_count, exp_takes));
            end
            else if (in_run) begin
                assert (busy) else report_mismatch("busy low during a run");
            end
            took_last = tap_valid && tap_take;
        end
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: the tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TESTBENCH FAILED");
        $finish;
    end

    task automatic load_memory(input int n_words);
        logic [63:0] word;
        for (int a = 0; a < n_words; a++) begin
            word       = take_bits(64);
            mem_img[a] = word;
            load_en    = 1'b1;
            load_addr  = a[conv_cfg_pkg::ADDR_W-1:0];
            load_data  = word;
            @(posedge clk);
            #DRIVE_DELAY;
        end
        load_en = 1'b0;
    endtask

    task automatic start_run(input int sw, input bit s2, input int rows);
        exp_start_word = sw;
        exp_stride     = s2;
        exp_takes      = rows * 3;
        take_count     = 0;
        done_count     = 0;
        stride2_en     = s2;
        start_word     = sw[conv_cfg_pkg::ADDR_W-1:0];
        row_count      = rows[conv_cfg_pkg::ROWS_W-1:0];
        start          = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        start  = 1'b0;
        in_run = 1'b1;
    endtask

    // takes n taps, optionally after a random stall of 0 to 7 valid cycles
    task automatic consume_taps(input int n, input bit gaps);
        int  taken;
        int  gap_left;
        bit  take_now;
        taken    = 0;
        gap_left = gaps ? int'(take_bits(3)) : 0;
        tap_take = (gap_left == 0);
        while (taken < n) begin
            @(negedge clk);
            take_now = tap_valid && tap_take;
            @(posedge clk);
            #DRIVE_DELAY;
            if (take_now) begin
                taken++;
                gap_left = gaps ? int'(take_bits(3)) : 0;
            end
            else if (tap_valid && gap_left > 0) begin
                gap_left--;
            end
            tap_take = (gap_left == 0) && (taken < n);
        end
        tap_take = 1'b0;
    endtask

    task automatic finish_run();
        bit seen;
        seen = 1'b0;
        for (int c = 0; c < 200 && !seen; c++) begin
            @(negedge clk);
            seen = done;
        end
        if (!seen) begin
            $display("done did not arrive within 200 cycles of the last take");
            errors++;
        end
        repeat (3) @(negedge clk);
        assert (done_count == 1)
        else report_mismatch($sformatf("done pulsed %0d times", done_count));
        assert (!busy && !tap_valid) else report_mismatch("busy or tap_valid high after done");
        @(posedge clk);
        #DRIVE_DELAY;
    endtask

    task automatic run_rows(input int sw, input bit s2, input int rows, input bit gaps);
        start_run(sw, s2, rows);
        consume_taps(rows * 3, gaps);
        finish_run();
    endtask

    task automatic end_test(input string name, input int errs_before);
        if (errors == errs_before) begin
            tests_passed++;
            $display("%s: pass", name);
        end
        else begin
            tests_failed++;
            $display("%s: fail with %0d errors", name, errors - errs_before);
        end
    endtask

    initial begin
        int errs_before;
        clr        = 1'b0;
        start      = 1'b0;
        stride2_en = 1'b0;
        start_word = '0;
        row_count  = '0;
        tap_take   = 1'b0;
        load_en    = 1'b0;
        load_addr  = '0;
        load_data  = '0;

        @(posedge rst_n);
        @(posedge clk);
        #DRIVE_DELAY;

        errs_before = errors;
        @(negedge clk);
        assert (!tap_valid && !busy && !done) else report_mismatch("outputs high after reset");
        repeat (20) begin
            @(negedge clk);
            assert (!tap_valid) else report_mismatch("tap_valid without start");
        end
        @(posedge clk);
        #DRIVE_DELAY;
        end_test("reset and idle", errs_before);

        load_memory(LOAD_WORDS);

        errs_before = errors;
        run_rows(0, 1'b0, 4, 1'b0);
        end_test("stride 1 from word 0", errs_before);

        errs_before = errors;
        run_rows(5, 1'b1, 3, 1'b0);
        end_test("stride 2 from word 5", errs_before);

        errs_before = errors;
        run_rows(20, 1'b0, 5, 1'b1);
        end_test("stride 1 with stalls", errs_before);

        errs_before = errors;
        run_rows(32, 1'b1, 2, 1'b1);
        end_test("done and busy timing", errs_before);

        // clr after four takes, then restart at the other stride
        errs_before = errors;
        start_run(0, 1'b0, 6);
        consume_taps(4, 1'b0);
        in_run = 1'b0;
        clr    = 1'b1;
        @(posedge clk);
        #DRIVE_DELAY;
        clr = 1'b0;
        @(negedge clk);
        assert (!tap_valid && !busy) else report_mismatch("tap_valid or busy high after clr");
        @(posedge clk);
        #DRIVE_DELAY;
        run_rows(40, 1'b1, 2, 1'b0);
        end_test("clr mid run and restart", errs_before);

        $display("tests passed %0d failed %0d, check errors %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0 && tests_failed == 0) begin
            $display("TESTBENCH PASSED");
        end
        else begin
            $display("TESTBENCH FAILED");
        end
        $finish;
    end

endmodule
